// ==== verilog/video_pkg.sv ====
/*
 * video_pkg: pixel coordinate and colour types shared by the raster stages
 */
`default_nettype none

package video_pkg;

	// screen coordinate, wide enough for 640x480 and smaller test frames
	typedef logic [9:0] coord_t;

	// colour in RGB332 packing: rrr_ggg_bb
	typedef logic [7:0] rgb_t;

endpackage : video_pkg

`default_nettype wire

// ==== verilog/game_pkg.sv ====
/*
 * game_pkg: object indices, Wishbone field types and the object palette
 */
`default_nettype none

package game_pkg;

	// number of game objects with a position register pair
	localparam int NUM_OBJ = 7;

	// object index, also selects the register pair at word address 2*id
	typedef enum logic [2:0] {
		PLAYER = 3'd0,
		ENEMY1 = 3'd1,
		ENEMY2 = 3'd2,
		BOMB   = 3'd3,
		BLAST  = 3'd4,
		COLUMN = 3'd5,
		WALL   = 3'd6
	} obj_id_t;

	typedef logic [3:0]  wb_adr_t;   // word address, 2*id = x, 2*id+1 = y
	typedef logic [15:0] wb_dat_t;   // only the low coordinate bits are kept

	// palette, RGB332
	localparam video_pkg::rgb_t PLAYER_RGB = 8'hE0; // red
	localparam video_pkg::rgb_t ENEMY1_RGB = 8'h1C; // green
	localparam video_pkg::rgb_t ENEMY2_RGB = 8'h1F; // cyan
	localparam video_pkg::rgb_t BLAST_RGB  = 8'hFC; // yellow
	localparam video_pkg::rgb_t BOMB_RGB   = 8'h49;
	localparam video_pkg::rgb_t COLUMN_RGB = 8'h92; // grey
	localparam video_pkg::rgb_t WALL_RGB   = 8'h6D;
	localparam video_pkg::rgb_t BG_RGB     = 8'h00; // black background

endpackage : game_pkg

`default_nettype wire

// ==== verilog/pixel_scanner.sv ====
/*
 * pixel_scanner: walks the active frame one pixel per clock in raster order
 * and flags the first pixel of every frame
 */
`timescale 1ns/1ps
`default_nettype none

module pixel_scanner #(
	parameter int H_ACTIVE = 640,
	parameter int V_ACTIVE = 480
) (
	input  logic              clk,
	input  logic              resetN,
	output video_pkg::coord_t pix_x,
	output video_pkg::coord_t pix_y,
	output logic              frame_start   // high while pixel (0,0) is out
);

	import video_pkg::*;

	coord_t next_x;
	coord_t next_y;
	logic   last_x;
	logic   last_y;

	assign last_x = (pix_x == coord_t'(H_ACTIVE - 1)); // end of line
	assign last_y = (pix_y == coord_t'(V_ACTIVE - 1)); // last line

	// next raster position, no blanking so wrap straight to 0
	always_comb begin
		next_x = pix_x + coord_t'(1);
		next_y = pix_y;
		if (last_x) begin
			next_x = '0;
			next_y = last_y ? '0 : pix_y + coord_t'(1);
		end
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			pix_x       <= '0;
			pix_y       <= '0;
			frame_start <= 1'b0;
		end else begin
			pix_x       <= next_x;
			pix_y       <= next_y;
			frame_start <= (next_x == '0) && (next_y == '0); // lines up with (0,0)
		end
	end

endmodule : pixel_scanner

`default_nettype wire

// ==== verilog/position_regs.sv ====
/*
 * position_regs: Wishbone classic slave holding the x and y position
 * of every game object, single-cycle registered ack
 */
`timescale 1ns/1ps
`default_nettype none

module position_regs (
	input  logic              clk,
	input  logic              resetN,
	input  logic              wb_cyc,
	input  logic              wb_stb,
	input  logic              wb_we,
	input  game_pkg::wb_adr_t wb_adr,
	input  game_pkg::wb_dat_t wb_dat_w,
	output game_pkg::wb_dat_t wb_dat_r,
	output logic              wb_ack,
	output video_pkg::coord_t obj_x [game_pkg::NUM_OBJ],
	output video_pkg::coord_t obj_y [game_pkg::NUM_OBJ]
);

	import video_pkg::*;
	import game_pkg::*;

	obj_id_t sel_id;   // object addressed
	logic    sel_y;    // 0: x register, 1: y register
	logic    sel_ok;   // address maps to a real register
	logic    req;      // cycle pending and not yet acknowledged

	assign req    = wb_cyc && wb_stb && !wb_ack;
	assign sel_id = obj_id_t'(wb_adr[3:1]);
	assign sel_y  = wb_adr[0];
	assign sel_ok = (wb_adr < wb_adr_t'(2 * NUM_OBJ)); // 14 and 15 are holes

	// ack for one clock, never back to back
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			wb_ack <= 1'b0;
		else
			wb_ack <= req;
	end

	// write lands on the same edge that raises ack
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			for (int i = 0; i < NUM_OBJ; i++) begin
				obj_x[i] <= '0;
				obj_y[i] <= '0;
			end
		end else if (req && wb_we && sel_ok) begin
			if (sel_y)
				obj_y[sel_id] <= coord_t'(wb_dat_w); // upper bits dropped
			else
				obj_x[sel_id] <= coord_t'(wb_dat_w);
		end
	end

	// read data, sampled with ack and held while ack is high
	always_ff @(posedge clk) begin
		if (req) begin
			if (!sel_ok)
				wb_dat_r <= '0;
			else if (sel_y)
				wb_dat_r <= wb_dat_t'(obj_y[sel_id]); // zero extended
			else
				wb_dat_r <= wb_dat_t'(obj_x[sel_id]);
		end
	end

endmodule : position_regs

`default_nettype wire

// ==== verilog/object_painter.sv ====
/*
 * object_painter: registered inside-rectangle test for one object,
 * forms the painter stage of the pixel pipeline
 */
`timescale 1ns/1ps
`default_nettype none

module object_painter #(
	parameter int OBJ_W = 16,
	parameter int OBJ_H = 16
) (
	input  logic              clk,
	input  logic              resetN,
	input  video_pkg::coord_t pix_x,
	input  video_pkg::coord_t pix_y,
	input  video_pkg::coord_t obj_x,   // top left corner
	input  video_pkg::coord_t obj_y,
	output logic              draw      // pixel covered, one clock late
);

	logic [10:0] right_edge;   // one bit wider so the edge cannot wrap
	logic [10:0] bottom_edge;
	logic        in_x;
	logic        in_y;

	assign right_edge  = {1'b0, obj_x} + 11'(OBJ_W);
	assign bottom_edge = {1'b0, obj_y} + 11'(OBJ_H);

	// half-open span [obj, obj+size)
	assign in_x = (pix_x >= obj_x) && ({1'b0, pix_x} < right_edge);
	assign in_y = (pix_y >= obj_y) && ({1'b0, pix_y} < bottom_edge);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			draw <= 1'b0;
		else
			draw <= in_x && in_y;
	end

endmodule : object_painter

`default_nettype wire

// ==== verilog/frame_compositor.sv ====
/*
 * frame_compositor: fixed priority colour select over the draw requests,
 * registered colour plus a frame marker aligned with it
 */
`timescale 1ns/1ps
`default_nettype none

module frame_compositor (
	input  logic             clk,
	input  logic             resetN,
	input  logic             frame_start,   // straight from the scanner
	input  logic             draw_player,
	input  logic             draw_enemy1,
	input  logic             draw_enemy2,
	input  logic             draw_bomb,
	input  logic             draw_blast,
	input  logic             draw_column,
	input  logic             draw_wall,
	output video_pkg::rgb_t  rgb,
	output logic             rgb_frame_start
);

	import video_pkg::*;
	import game_pkg::*;

	rgb_t rgb_next;
	logic frame_d;   // frame marker in step with the draw signals

	// highest priority first
	always_comb begin
		if (draw_player)       rgb_next = PLAYER_RGB;
		else if (draw_enemy1)  rgb_next = ENEMY1_RGB;
		else if (draw_enemy2)  rgb_next = ENEMY2_RGB;
		else if (draw_blast)   rgb_next = BLAST_RGB;   // blast covers the bomb
		else if (draw_bomb)    rgb_next = BOMB_RGB;
		else if (draw_column)  rgb_next = COLUMN_RGB;
		else if (draw_wall)    rgb_next = WALL_RGB;
		else                   rgb_next = BG_RGB;
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			frame_d         <= 1'b0;
			rgb             <= BG_RGB;
			rgb_frame_start <= 1'b0;
		end else begin
			frame_d         <= frame_start;
			rgb             <= rgb_next;
			rgb_frame_start <= frame_d; // high with pixel (0,0) on rgb
		end
	end

endmodule : frame_compositor

`default_nettype wire

// ==== verilog/collision_detector.sv ====
/*
 * collision_detector: registered per-pixel collision flags and
 * at most one hit pulse per frame for the player and for the enemies
 */
`timescale 1ns/1ps
`default_nettype none

module collision_detector (
	input  logic clk,
	input  logic resetN,
	input  logic frame_start,
	input  logic draw_player,
	input  logic draw_enemy1,
	input  logic draw_enemy2,
	input  logic draw_bomb,
	input  logic draw_blast,
	input  logic draw_column,
	input  logic draw_wall,
	output logic player_blocked,   // player on column or wall
	output logic enemy1_blocked,
	output logic enemy2_blocked,
	output logic blast_on_wall,
	output logic player_hit,       // single pulse per frame
	output logic enemy_hit
);

	logic frame_d;         // frame start lined up with the draw signals
	logic player_armed;    // no player hit yet this frame
	logic enemy_armed;
	logic player_coll;
	logic enemy_coll;
	logic player_fire;
	logic enemy_fire;

	// hit conditions for the current pixel
	assign player_coll = draw_player && (draw_column || draw_wall || draw_blast);
	assign enemy_coll  = (draw_enemy1 || draw_enemy2) && draw_blast;

	// a hit on the frame start pixel belongs to the new frame
	assign player_fire = player_coll && (player_armed || frame_d);
	assign enemy_fire  = enemy_coll && (enemy_armed || frame_d);

	// level flags, one per pixel
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			frame_d        <= 1'b0;
			player_blocked <= 1'b0;
			enemy1_blocked <= 1'b0;
			enemy2_blocked <= 1'b0;
			blast_on_wall  <= 1'b0;
		end else begin
			frame_d        <= frame_start;
			player_blocked <= draw_player && (draw_column || draw_wall);
			enemy1_blocked <= draw_enemy1 && (draw_column || draw_wall || draw_bomb);
			enemy2_blocked <= draw_enemy2 && (draw_column || draw_wall || draw_bomb);
			blast_on_wall  <= draw_blast && draw_wall && !draw_column;
		end
	end

	// once-per-frame pulses, each with its own arm flag
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			player_armed <= 1'b1;
			enemy_armed  <= 1'b1;
			player_hit   <= 1'b0;
			enemy_hit    <= 1'b0;
		end else begin
			player_hit <= player_fire;
			enemy_hit  <= enemy_fire;
			if (player_fire)
				player_armed <= 1'b0;   // used up until next frame
			else if (frame_d)
				player_armed <= 1'b1;
			if (enemy_fire)
				enemy_armed <= 1'b0;
			else if (frame_d)
				enemy_armed <= 1'b1;
		end
	end

endmodule : collision_detector

`default_nettype wire

// ==== verilog/game_display_top.sv ====
/*
 * game_display_top: position registers, raster scanner, seven painters,
 * compositor and collision detector of the game display pipeline
 */
`timescale 1ns/1ps
`default_nettype none

module game_display_top #(
	parameter int H_ACTIVE = 640,
	parameter int V_ACTIVE = 480,
	parameter int PLAYER_W = 16, parameter int PLAYER_H = 16,
	parameter int ENEMY1_W = 16, parameter int ENEMY1_H = 16,
	parameter int ENEMY2_W = 16, parameter int ENEMY2_H = 16,
	parameter int BOMB_W   = 8,  parameter int BOMB_H   = 8,
	parameter int BLAST_W  = 32, parameter int BLAST_H  = 32,
	parameter int COLUMN_W = 16, parameter int COLUMN_H = 480,
	parameter int WALL_W   = 640, parameter int WALL_H  = 16
) (
	input  logic              clk,
	input  logic              resetN,
	input  logic              wb_cyc,
	input  logic              wb_stb,
	input  logic              wb_we,
	input  game_pkg::wb_adr_t wb_adr,
	input  game_pkg::wb_dat_t wb_dat_w,
	output game_pkg::wb_dat_t wb_dat_r,
	output logic              wb_ack,
	output video_pkg::rgb_t   rgb,
	output logic              rgb_frame_start,
	output logic              player_blocked,
	output logic              enemy1_blocked,
	output logic              enemy2_blocked,
	output logic              blast_on_wall,
	output logic              player_hit,
	output logic              enemy_hit
);

	import video_pkg::*;
	import game_pkg::*;

	coord_t obj_x [NUM_OBJ];
	coord_t obj_y [NUM_OBJ];
	coord_t pix_x, pix_y;
	logic   frame_start;
	logic   draw_player, draw_enemy1, draw_enemy2, draw_bomb;
	logic   draw_blast, draw_column, draw_wall;

	position_regs u_regs (.clk, .resetN, .wb_cyc, .wb_stb, .wb_we, .wb_adr,
		.wb_dat_w, .wb_dat_r, .wb_ack, .obj_x, .obj_y);

	pixel_scanner #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) u_scan (
		.clk, .resetN, .pix_x, .pix_y, .frame_start);

	// one painter per object, sizes from the top parameters
	object_painter #(.OBJ_W(PLAYER_W), .OBJ_H(PLAYER_H)) u_player (.clk, .resetN,
		.pix_x, .pix_y, .obj_x(obj_x[PLAYER]), .obj_y(obj_y[PLAYER]), .draw(draw_player));
	object_painter #(.OBJ_W(ENEMY1_W), .OBJ_H(ENEMY1_H)) u_enemy1 (.clk, .resetN,
		.pix_x, .pix_y, .obj_x(obj_x[ENEMY1]), .obj_y(obj_y[ENEMY1]), .draw(draw_enemy1));
	object_painter #(.OBJ_W(ENEMY2_W), .OBJ_H(ENEMY2_H)) u_enemy2 (.clk, .resetN,
		.pix_x, .pix_y, .obj_x(obj_x[ENEMY2]), .obj_y(obj_y[ENEMY2]), .draw(draw_enemy2));
	object_painter #(.OBJ_W(BOMB_W), .OBJ_H(BOMB_H)) u_bomb (.clk, .resetN,
		.pix_x, .pix_y, .obj_x(obj_x[BOMB]), .obj_y(obj_y[BOMB]), .draw(draw_bomb));
	object_painter #(.OBJ_W(BLAST_W), .OBJ_H(BLAST_H)) u_blast (.clk, .resetN,
		.pix_x, .pix_y, .obj_x(obj_x[BLAST]), .obj_y(obj_y[BLAST]), .draw(draw_blast));
	object_painter #(.OBJ_W(COLUMN_W), .OBJ_H(COLUMN_H)) u_column (.clk, .resetN,
		.pix_x, .pix_y, .obj_x(obj_x[COLUMN]), .obj_y(obj_y[COLUMN]), .draw(draw_column));
	object_painter #(.OBJ_W(WALL_W), .OBJ_H(WALL_H)) u_wall (.clk, .resetN,
		.pix_x, .pix_y, .obj_x(obj_x[WALL]), .obj_y(obj_y[WALL]), .draw(draw_wall));

	// colour and collisions side by side, same pipeline depth
	frame_compositor u_comp (.clk, .resetN, .frame_start, .draw_player, .draw_enemy1,
		.draw_enemy2, .draw_bomb, .draw_blast, .draw_column, .draw_wall,
		.rgb, .rgb_frame_start);

	collision_detector u_coll (.clk, .resetN, .frame_start, .draw_player, .draw_enemy1,
		.draw_enemy2, .draw_bomb, .draw_blast, .draw_column, .draw_wall,
		.player_blocked, .enemy1_blocked, .enemy2_blocked, .blast_on_wall,
		.player_hit, .enemy_hit);

endmodule : game_display_top

`default_nettype wire

// ==== tests/game_display_properties.sv ====
/*
 * game_display_properties: Wishbone ack handshake and once-per-frame hit pulse
 * assertions, bound into the register block and the collision detector
 */
`timescale 1ns/1ps
`default_nettype none

module game_display_properties (
	input logic clk,
	input logic resetN,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_ack,
	input logic frame_mark,   // frame start in step with the draw signals
	input logic player_hit,
	input logic enemy_hit
);

	logic mark_q;        // frame start in step with the hit outputs
	logic player_seen;   // player hit already given this frame
	logic enemy_seen;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			mark_q      <= 1'b0;
			player_seen <= 1'b0;
			enemy_seen  <= 1'b0;
		end else begin
			mark_q      <= frame_mark;
			player_seen <= mark_q ? player_hit : (player_seen || player_hit); // new frame restarts
			enemy_seen  <= mark_q ? enemy_hit : (enemy_seen || enemy_hit);
		end
	end

	// ack is a single clock and only answers a strobe
	ack_single: assert property (@(posedge clk) disable iff (!resetN) wb_ack |=> !wb_ack)
		else $error("wb_ack high for two cycles in a row");
	ack_after_stb: assert property (@(posedge clk) disable iff (!resetN)
		wb_ack |-> $past(wb_cyc && wb_stb))
		else $error("wb_ack without cyc and stb on the previous clock");

	// at most one pulse of each kind between aligned frame starts
	player_once: assert property (@(posedge clk) disable iff (!resetN)
		(player_hit && !mark_q) |-> !player_seen)
		else $error("second player_hit within one frame");
	enemy_once: assert property (@(posedge clk) disable iff (!resetN)
		(enemy_hit && !mark_q) |-> !enemy_seen)
		else $error("second enemy_hit within one frame");

endmodule : game_display_properties

bind position_regs game_display_properties u_bus_props (
	.clk(clk), .resetN(resetN), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_ack(wb_ack),
	.frame_mark(1'b0), .player_hit(1'b0), .enemy_hit(1'b0));   // hit side idle here

bind collision_detector game_display_properties u_hit_props (
	.clk(clk), .resetN(resetN), .wb_cyc(1'b0), .wb_stb(1'b0), .wb_ack(1'b0),
	.frame_mark(frame_d), .player_hit(player_hit), .enemy_hit(enemy_hit));

`default_nettype wire

// ==== tests/tb_game_display.sv ====
/*
 * Directed testbench for the game display pipeline that checks register access,
 * frame colours, collision flags and hit pulses
 */
`timescale 1ns/1ps
`default_nettype none

module tb_game_display;

	localparam int H = 32;                        // small test frame
	localparam int V = 24;
	localparam int NPIX = H * V;
	localparam int BUS_LIMIT = 16;                // clocks to wait for ack
	localparam int FRAME_LIMIT = 2 * NPIX + 16;

	logic              clk;
	logic              resetN;
	logic              wb_cyc;
	logic              wb_stb;
	logic              wb_we;
	game_pkg::wb_adr_t wb_adr;
	game_pkg::wb_dat_t wb_dat_w;
	game_pkg::wb_dat_t wb_dat_r;
	logic              wb_ack;
	video_pkg::rgb_t   rgb;
	logic              rgb_frame_start;
	logic              player_blocked, enemy1_blocked, enemy2_blocked, blast_on_wall;
	logic              player_hit, enemy_hit;

	int errors = 0;
	int timeouts = 0;
	int seed = 98;                                // $random seed
	int scene [14];                               // x,y pairs in register order
	int ox [7];                                   // positions as the model sees them
	int oy [7];
	int ow [7] = '{4, 4, 4, 4, 4, 2, 32};         // player enemy1 enemy2 bomb blast column wall
	int oh [7] = '{4, 4, 4, 4, 4, 24, 2};
	int rgb_cap [NPIX];
	int flag_cap [NPIX];                          // 4 level flags, player_hit, enemy_hit

	game_display_top #(
		.H_ACTIVE(H), .V_ACTIVE(V),
		.PLAYER_W(4), .PLAYER_H(4), .ENEMY1_W(4), .ENEMY1_H(4),
		.ENEMY2_W(4), .ENEMY2_H(4), .BOMB_W(4), .BOMB_H(4),
		.BLAST_W(4), .BLAST_H(4), .COLUMN_W(2), .COLUMN_H(24),
		.WALL_W(32), .WALL_H(2)
	) uut (.clk, .resetN, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r,
		.wb_ack, .rgb, .rgb_frame_start, .player_blocked, .enemy1_blocked,
		.enemy2_blocked, .blast_on_wall, .player_hit, .enemy_hit);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check(input int got, input int want, input string what);
		if (got != want) begin
			errors++;
			$display("mismatch at %0t: %s, got %0h expected %0h", $time, what, got, want);
		end
	endtask

	// one classic cycle with strobe held until ack, started on a falling edge
	task automatic bus_cycle(input logic we, input int adr, input int wdata, output int rdata);
		int n;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = 4'(adr);
		wb_dat_w = 16'(wdata);
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!wb_ack && n < BUS_LIMIT);
		rdata = int'(wb_dat_r);  // valid while ack is high
		if (!wb_ack) begin
			timeouts++;
			$display("no ack from the register block at address %0d", adr);
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic wb_write(input int adr, input int data);
		int ignored;
		bus_cycle(1'b1, adr, data, ignored);
	endtask

	task automatic wb_read(input int adr, output int data);
		bus_cycle(1'b0, adr, 0, data);
	endtask

	// write all positions and keep the stored 10 bits for the model
	task automatic load_scene();
		for (int a = 0; a < 14; a++) begin
			wb_write(a, scene[a]);
			if (a % 2 == 0)
				ox[a / 2] = scene[a] & 'h3FF;
			else
				oy[a / 2] = scene[a] & 'h3FF;
		end
	endtask

	task automatic wait_frame();
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!rgb_frame_start && n < FRAME_LIMIT);
		if (!rgb_frame_start) begin
			timeouts++;
			$display("no frame marker on rgb within %0d clocks", FRAME_LIMIT);
		end
	endtask

	// records one whole frame from the marker on at falling edges
	task automatic capture_frame();
		wait_frame();
		for (int i = 0; i < NPIX; i++) begin
			if (i > 0)
				@(negedge clk);
			rgb_cap[i] = int'(rgb);
			flag_cap[i] = int'({player_blocked, enemy1_blocked, enemy2_blocked,
				blast_on_wall, player_hit, enemy_hit});
		end
	endtask

	// bit i set where the half-open rectangle of object i covers the pixel
	function automatic int cover_mask(input int x, input int y);
		int m;
		m = 0;
		for (int i = 0; i < 7; i++)
			if (x >= ox[i] && x < ox[i] + ow[i] && y >= oy[i] && y < oy[i] + oh[i])
				m |= 1 << i;
		return m;
	endfunction

	function automatic int expected_rgb(input int m);
		if (m[0]) return 'hE0;        // player
		if (m[1]) return 'h1C;        // enemy1
		if (m[2]) return 'h1F;        // enemy2
		if (m[4]) return 'hFC;        // blast over bomb
		if (m[3]) return 'h49;
		if (m[5]) return 'h92;        // column
		if (m[6]) return 'h6D;        // wall
		return 'h00;
	endfunction

	// same bit order as flag_cap with the hit conditions in the low two bits
	function automatic int expected_flags(input int m);
		int f;
		f = 0;
		if (m[0] && (m[5] || m[6])) f |= 32;
		if (m[1] && (m[5] || m[6] || m[3])) f |= 16;
		if (m[2] && (m[5] || m[6] || m[3])) f |= 8;
		if (m[4] && m[6] && !m[5]) f |= 4;
		if (m[0] && (m[5] || m[6] || m[4])) f |= 2;
		if ((m[1] || m[2]) && m[4]) f |= 1;
		return f;
	endfunction

	task automatic check_frame(input string name);
		int m;
		capture_frame();
		for (int i = 0; i < NPIX; i++) begin
			m = cover_mask(i % H, i / H);
			check(rgb_cap[i], expected_rgb(m),
				$sformatf("%s colour at (%0d,%0d)", name, i % H, i / H));
			check(flag_cap[i] >> 2, expected_flags(m) >> 2,
				$sformatf("%s level flags at (%0d,%0d)", name, i % H, i / H));
		end
	endtask

	// pulse count and place against the first overlap of the frame
	task automatic check_hits(input string name);
		int f;
		int got_n [2];
		int got_first [2];
		int exp_first [2];
		got_n = '{0, 0};
		got_first = '{-1, -1};
		exp_first = '{-1, -1};
		capture_frame();
		for (int i = 0; i < NPIX; i++) begin
			f = expected_flags(cover_mask(i % H, i / H));
			for (int k = 0; k < 2; k++) begin
				if (((f >> k) & 1) != 0 && exp_first[k] < 0)
					exp_first[k] = i;
				if (((flag_cap[i] >> k) & 1) != 0) begin
					got_n[k]++;
					if (got_first[k] < 0)
						got_first[k] = i;
				end
			end
		end
		for (int k = 0; k < 2; k++) begin
			check(got_n[k], exp_first[k] >= 0 ? 1 : 0,
				$sformatf("%s %s_hit pulses", name, k == 1 ? "player" : "enemy"));
			check(got_first[k], exp_first[k],
				$sformatf("%s %s_hit pixel", name, k == 1 ? "player" : "enemy"));
		end
	endtask

	task automatic bus_access();
		int wr [14];
		int rd;
		for (int a = 0; a < 14; a++) begin
			wr[a] = $random(seed) & 'hFFFF;  // upper bits must be dropped
			scene[a] = wr[a];
		end
		load_scene();
		for (int a = 0; a < 14; a++) begin
			wb_read(a, rd);
			check(rd, wr[a] & 'h3FF, $sformatf("readback of register %0d", a));
		end
		wb_write(14, 'hFFFF);
		wb_write(15, 'h03FF);
		wb_read(14, rd);
		check(rd, 0, "read of unused address 14");
		wb_read(15, rd);
		check(rd, 0, "read of unused address 15");
		for (int a = 0; a < 14; a++) begin
			wb_read(a, rd);
			check(rd, wr[a] & 'h3FF,
				$sformatf("register %0d after writes to unused addresses", a));
		end
	endtask

	// sprites kept apart so that only the column and the wall meet
	task automatic colour_map();
		scene = '{2, 2, 8, 2, 14, 2, 20, 2, 2, 10, 30, 0, 0, 20};
		load_scene();
		wait_frame();
		check_frame("colour map");
	endtask

	// player, enemy1 and blast stacked, enemy2 and bomb each clip one blast corner
	task automatic priority_overlap();
		scene = '{4, 4, 6, 6, 2, 8, 8, 2, 5, 5, 26, 0, 0, 22};
		load_scene();
		wait_frame();
		check_frame("priority");
		check(rgb_cap[6 * H + 6], 'hE0, "player over enemy1 and blast");
		check(rgb_cap[8 * H + 8], 'h1C, "enemy1 over blast");
		check(rgb_cap[8 * H + 5], 'h1F, "enemy2 over blast");
		check(rgb_cap[5 * H + 8], 'hFC, "blast over bomb");
	endtask

	// player on column, enemy1 on wall, enemy2 on bomb, blast on wall beside the column
	task automatic level_flags();
		scene = '{11, 4, 20, 15, 24, 6, 26, 8, 10, 14, 12, 0, 0, 16};
		load_scene();
		wait_frame();
		check_frame("level flags");
	endtask

	task automatic hit_pulses();
		scene = '{11, 4, 100, 100, 20, 4, 100, 100, 22, 6, 12, 0, 0, 100};
		load_scene();
		wait_frame();
		repeat (3) check_hits("overlap");
		scene = '{2, 2, 100, 100, 20, 4, 100, 100, 26, 16, 12, 0, 0, 100};
		load_scene();
		wait_frame();
		repeat (2) check_hits("apart");
	endtask

	initial begin
		resetN = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		repeat (5) @(negedge clk);
		resetN = 1'b1;
		bus_access();
		colour_map();
		priority_overlap();
		level_flags();
		hit_pulses();
		$display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule : tb_game_display

`default_nettype wire

// ==== tb.f ====
verilog/video_pkg.sv
verilog/game_pkg.sv
verilog/pixel_scanner.sv
verilog/position_regs.sv
verilog/object_painter.sv
verilog/frame_compositor.sv
verilog/collision_detector.sv
verilog/game_display_top.sv
tests/game_display_properties.sv
tests/tb_game_display.sv

// ==== run.sh ====
#!/bin/sh
# build and run the game display testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_game_display \
	-Mdir obj_dir -o sim_game_display -f tb.f
./obj_dir/sim_game_display > sim.log 2>&1 || true
cat sim.log
if grep -qx "STATUS: PASS" sim.log; then
	exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1
